//--- rtl/ats_macros.svh
// sizes, field widths and encodings for the alarm/timer unit, included by packages and RTL
`ifndef ATS_MACROS_SVH
`define ATS_MACROS_SVH

//////////////////////////////
// sizes and widths
`define ATS_NUM_CLOCKS   16   // programmable counters
`define ATS_NUM_ALARMS   24   // alarm/timer slots, one data bit each
`define ATS_CLOCK_IDX_W  4
`define ATS_ALARM_IDX_W  5
`define ATS_COUNT_W      16   // counter and alarm value
`define ATS_HALF_W       16   // client port carries half an instruction

//////////////////////////////
// opcodes in bits [31:29]
`define ATS_OP_NOP        3'b000
`define ATS_OP_SET_CLOCK  3'b001
`define ATS_OP_EN_CLOCK   3'b010
`define ATS_OP_SET_MODE   3'b011
`define ATS_OP_SET_ALARM  3'b101
`define ATS_OP_SET_TIMER  3'b110
`define ATS_OP_EN_ALARM   3'b111

// counter rate codes, 11 stays frozen
`define ATS_RATE_1X  2'b00
`define ATS_RATE_2X  2'b01
`define ATS_RATE_4X  2'b10

`endif

//--- rtl/atsInstrPkg.sv
// instruction word layouts seen by the host ports and decoded by the request arbiter
`include "ats_macros.svh"

package atsInstrPkg;

  typedef enum logic [2:0] {
    OP_NOP       = `ATS_OP_NOP,
    OP_SET_CLOCK = `ATS_OP_SET_CLOCK,
    OP_EN_CLOCK  = `ATS_OP_EN_CLOCK,
    OP_SET_MODE  = `ATS_OP_SET_MODE,
    OP_SET_ALARM = `ATS_OP_SET_ALARM,
    OP_SET_TIMER = `ATS_OP_SET_TIMER,
    OP_EN_ALARM  = `ATS_OP_EN_ALARM
  } opcode_e;   // 100 left undefined

  // set clock / enable clock
  typedef struct packed {
    opcode_e                     opcode;
    logic [`ATS_CLOCK_IDX_W-1:0] clockIdx;
    logic                        pad0;
    logic [1:0]                  enRate;    // rate, or bit 23 = enable
    logic [5:0]                  pad1;
    logic [`ATS_COUNT_W-1:0]     count;     // start count
  } clockInstr_t;

  // set alarm / set timer / enable alarm
  typedef struct packed {
    opcode_e                     opcode;
    logic [`ATS_ALARM_IDX_W-1:0] alarmIdx;
    logic                        repEn;     // repeat, or enable
    logic [2:0]                  pad;
    logic [`ATS_CLOCK_IDX_W-1:0] clockIdx;
    logic [`ATS_COUNT_W-1:0]     value;     // alarm value or interval
  } alarmInstr_t;

  // set mode
  typedef struct packed {
    opcode_e     opcode;
    logic        active;
    logic        clockPerm;
    logic        alarmPerm;
    logic [25:0] pad;
  } modeInstr_t;

  // one word, read through whichever view its opcode selects
  typedef union packed {
    clockInstr_t clockView;
    alarmInstr_t alarmView;
    modeInstr_t  modeView;
  } instrWord_u;

  typedef struct packed {
    logic       valid;   // one cycle per instruction
    instrWord_u word;
  } hostInstr_t;

endpackage

//--- rtl/atsStatePkg.sv
// write requests and mode register layout passed between arbiter and the two banks
`include "ats_macros.svh"

package atsStatePkg;

  // what an alarm write does to its slot
  typedef enum logic [1:0] {
    AW_SET_ALARM = 2'd0,
    AW_SET_TIMER = 2'd1,
    AW_ENABLE    = 2'd2
  } alarmKind_e;

  typedef struct packed {
    logic                        valid;
    logic                        loadCount;  // set clock, else enable only
    logic [`ATS_CLOCK_IDX_W-1:0] index;
    logic                        enable;
    logic [1:0]                  rate;
    logic [`ATS_COUNT_W-1:0]     count;
  } clockWrite_t;

  typedef struct packed {
    logic                        valid;
    alarmKind_e                  kind;
    logic [`ATS_ALARM_IDX_W-1:0] index;
    logic                        repEn;      // repeat for set alarm, enable for enable
    logic [`ATS_CLOCK_IDX_W-1:0] clockIdx;
    logic [`ATS_COUNT_W-1:0]     value;      // value or timer interval
  } alarmWrite_t;

  // global mode, all ones out of reset
  typedef struct packed {
    logic active;
    logic clockPermA;
    logic clockPermB;
    logic alarmPermA;
    logic alarmPermB;
  } modeReg_t;

endpackage

//--- rtl/hostPort.sv
// collects one client's upper and lower 16-bit halves into a single registered instruction
`timescale 1ns/10ps
`include "ats_macros.svh"

module hostPort (
  input  logic                     clk_1x,
  input  logic                     reset,
  input  logic                     req,
  input  logic                     active,   // device active bit from mode register
  input  logic [`ATS_HALF_W-1:0]   ctrl,
  output atsInstrPkg::hostInstr_t  instr
);

  logic                   half;      // upper half held, lower expected now
  logic [`ATS_HALF_W-1:0] upper;
  logic                   validQ;
  logic [31:0]            wordQ;

  // upper half starts only with req, active and a real opcode
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      half   <= 1'b0;
      validQ <= 1'b0;
    end else begin
      validQ <= half;   // lower half arrives this cycle
      if (half)
        half <= 1'b0;
      else if (req && active && (ctrl[15:13] != `ATS_OP_NOP))
        half <= 1'b1;
    end
  end

  always_ff @(posedge clk_1x) begin
    if (!half)
      upper <= ctrl;            // kept once half goes high
    else
      wordQ <= {upper, ctrl};   // lower half taken regardless of req
  end

  assign instr.valid = validQ;
  assign instr.word  = wordQ;

  // at most one instruction every two cycles
  assert property (@(posedge clk_1x) disable iff (reset) validQ |=> !validQ);

endmodule

//--- rtl/requestArbiter.sv
// checks both clients' instructions for conflicts and permission, keeps mode and status
`timescale 1ns/10ps
`include "ats_macros.svh"

module requestArbiter (
  input  logic                     clk_1x,
  input  logic                     reset,
  input  atsInstrPkg::hostInstr_t  instrA,
  input  atsInstrPkg::hostInstr_t  instrB,
  output logic                     active,
  output logic [1:0]               stat,      // bit 0 client A, bit 1 client B
  output atsStatePkg::clockWrite_t clockWrA,
  output atsStatePkg::clockWrite_t clockWrB,
  output atsStatePkg::alarmWrite_t alarmWrA,
  output atsStatePkg::alarmWrite_t alarmWrB
);

  // one client's decoded instruction before conflict masking
  typedef struct packed {
    logic                     ack;
    logic                     setMode;
    atsStatePkg::clockWrite_t clockWr;
    atsStatePkg::alarmWrite_t alarmWr;
  } decode_t;

  atsStatePkg::modeReg_t mode;
  atsInstrPkg::opcode_e  opA, opB;
  logic                  sameClock, sameSlot, pairAT;
  logic                  conflict;
  decode_t               decA, decB;
  logic                  ackA, ackB;

  function automatic decode_t decode(input atsInstrPkg::instrWord_u w,
                                     input logic clockPerm,
                                     input logic alarmPerm);
    decode_t d;
    d = '0;
    case (w.clockView.opcode)
      atsInstrPkg::OP_SET_CLOCK, atsInstrPkg::OP_EN_CLOCK: begin
        d.ack               = clockPerm;
        d.clockWr.valid     = clockPerm;
        d.clockWr.loadCount = (w.clockView.opcode == atsInstrPkg::OP_SET_CLOCK);
        d.clockWr.index     = w.clockView.clockIdx;
        d.clockWr.enable    = d.clockWr.loadCount | w.clockView.enRate[1]; // set always enables
        d.clockWr.rate      = w.clockView.enRate;
        d.clockWr.count     = w.clockView.count;
      end
      atsInstrPkg::OP_SET_ALARM, atsInstrPkg::OP_SET_TIMER, atsInstrPkg::OP_EN_ALARM: begin
        d.ack              = alarmPerm;
        d.alarmWr.valid    = alarmPerm;
        if (w.alarmView.opcode == atsInstrPkg::OP_SET_ALARM)
          d.alarmWr.kind = atsStatePkg::AW_SET_ALARM;
        else if (w.alarmView.opcode == atsInstrPkg::OP_SET_TIMER)
          d.alarmWr.kind = atsStatePkg::AW_SET_TIMER;
        else
          d.alarmWr.kind = atsStatePkg::AW_ENABLE;
        d.alarmWr.index    = w.alarmView.alarmIdx;
        d.alarmWr.repEn    = w.alarmView.repEn;
        d.alarmWr.clockIdx = w.alarmView.clockIdx;
        d.alarmWr.value    = w.alarmView.value;
      end
      atsInstrPkg::OP_SET_MODE: begin
        d.ack     = 1'b1;   // mode change never refused
        d.setMode = 1'b1;
      end
      default: d.ack = 1'b0;   // undefined opcode 100
    endcase
    return d;
  endfunction

  //////////////////////////////
  // conflict detection

  assign opA       = instrA.word.clockView.opcode;
  assign opB       = instrB.word.clockView.opcode;
  assign sameClock = (instrA.word.clockView.clockIdx == instrB.word.clockView.clockIdx);
  assign sameSlot  = (instrA.word.alarmView.alarmIdx == instrB.word.alarmView.alarmIdx);
  assign pairAT    = ((opA == atsInstrPkg::OP_SET_ALARM) && (opB == atsInstrPkg::OP_SET_TIMER)) ||
                     ((opA == atsInstrPkg::OP_SET_TIMER) && (opB == atsInstrPkg::OP_SET_ALARM));

  always_comb begin
    conflict = 1'b0;
    if (instrA.valid && instrB.valid) begin
      if (opA == opB) begin
        case (opA)
          atsInstrPkg::OP_SET_CLOCK, atsInstrPkg::OP_EN_CLOCK: conflict = sameClock;
          atsInstrPkg::OP_SET_ALARM, atsInstrPkg::OP_SET_TIMER,
          atsInstrPkg::OP_EN_ALARM:  conflict = sameSlot;
          atsInstrPkg::OP_SET_MODE:  conflict = 1'b1;   // two mode writes never mix
          default:                   conflict = 1'b0;
        endcase
      end else if (pairAT) begin
        conflict = sameSlot;   // alarm vs timer on one slot
      end
    end
  end

  //////////////////////////////
  // per-client issue

  assign decA = decode(instrA.word, mode.clockPermA, mode.alarmPermA);
  assign decB = decode(instrB.word, mode.clockPermB, mode.alarmPermB);
  assign ackA = instrA.valid && !conflict && decA.ack;
  assign ackB = instrB.valid && !conflict && decB.ack;

  always_comb begin
    clockWrA       = decA.clockWr;
    clockWrA.valid = ackA && decA.clockWr.valid;
    alarmWrA       = decA.alarmWr;
    alarmWrA.valid = ackA && decA.alarmWr.valid;
    clockWrB       = decB.clockWr;
    clockWrB.valid = ackB && decB.clockWr.valid;
    alarmWrB       = decB.alarmWr;
    alarmWrB.valid = ackB && decB.alarmWr.valid;
  end

  // status only moves when that client issues
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      mode <= '1;
      stat <= 2'b00;
    end else begin
      if (instrA.valid) stat[0] <= ackA;
      if (instrB.valid) stat[1] <= ackB;
      if (ackA && decA.setMode) begin
        mode.active     <= instrA.word.modeView.active;
        mode.clockPermA <= instrA.word.modeView.clockPerm;
        mode.alarmPermA <= instrA.word.modeView.alarmPerm;
      end
      if (ackB && decB.setMode) begin
        mode.active     <= instrB.word.modeView.active;
        mode.clockPermB <= instrB.word.modeView.clockPerm;
        mode.alarmPermB <= instrB.word.modeView.alarmPerm;
      end
    end
  end

  assign active = mode.active;

  // a Nack seen on stat means nothing reached the banks
  assert property (@(posedge clk_1x) disable iff (reset)
    instrA.valid |=> stat[0] || !$past(clockWrA.valid || alarmWrA.valid));
  assert property (@(posedge clk_1x) disable iff (reset)
    instrB.valid |=> stat[1] || !$past(clockWrB.valid || alarmWrB.valid));

endmodule

//--- rtl/clockBank.sv
// rate prescaler and the programmable counters, with per-counter tick enables for the alarms
`timescale 1ns/10ps
`include "ats_macros.svh"

module clockBank (
  input  logic                                           clk_1x,
  input  logic                                           reset,
  input  atsStatePkg::clockWrite_t                       clockWrA,
  input  atsStatePkg::clockWrite_t                       clockWrB,
  output logic [`ATS_NUM_CLOCKS-1:0][`ATS_COUNT_W-1:0]   counts,
  output logic [`ATS_NUM_CLOCKS-1:0]                     ticks   // counter steps this edge
);

  atsStatePkg::clockWrite_t          wr [2];     // A first, B wins on overlap
  logic [1:0]                        prescale;
  logic [`ATS_NUM_CLOCKS-1:0]        enable;
  logic [`ATS_NUM_CLOCKS-1:0][1:0]   rate;
  logic [`ATS_NUM_CLOCKS-1:0]        loaded;     // count overwritten this edge

  assign wr[0] = clockWrA;
  assign wr[1] = clockWrB;

  // free-running from reset
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) prescale <= 2'd0;
    else       prescale <= prescale + 2'd1;
  end

  always_comb begin
    for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
      case (rate[i])
        `ATS_RATE_1X: ticks[i] = enable[i];
        `ATS_RATE_2X: ticks[i] = enable[i] & prescale[0];   // every second cycle
        `ATS_RATE_4X: ticks[i] = enable[i] & (&prescale);   // every fourth
        default:      ticks[i] = 1'b0;
      endcase
      loaded[i] = 1'b0;
      for (int w = 0; w < 2; w++)
        if (wr[w].valid && wr[w].loadCount && (wr[w].index == `ATS_CLOCK_IDX_W'(i)))
          loaded[i] = 1'b1;
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      enable <= '0;
      rate   <= '0;
      counts <= '0;
    end else begin
      for (int i = 0; i < `ATS_NUM_CLOCKS; i++)
        if (ticks[i]) counts[i] <= counts[i] + 1'b1;   // wraps at 16 bits
      for (int w = 0; w < 2; w++) begin
        if (wr[w].valid) begin
          enable[wr[w].index] <= wr[w].enable;
          if (wr[w].loadCount) begin
            rate[wr[w].index]   <= wr[w].rate;
            counts[wr[w].index] <= wr[w].count;
          end
        end
      end
    end
  end

  // rate 11 holds its count until reloaded
  for (genvar g = 0; g < `ATS_NUM_CLOCKS; g++) begin : g_frozen
    assert property (@(posedge clk_1x) disable iff (reset)
      (rate[g] == 2'b11) && !loaded[g] |=> counts[g] == $past(counts[g]));
  end

endmodule

//--- rtl/alarmBank.sv
// alarm and countdown slots compared against the counters, each driving a two-cycle data pulse
`timescale 1ns/10ps
`include "ats_macros.svh"

module alarmBank (
  input  logic                                         clk_1x,
  input  logic                                         reset,
  input  atsStatePkg::alarmWrite_t                     alarmWrA,
  input  atsStatePkg::alarmWrite_t                     alarmWrB,
  input  logic [`ATS_NUM_CLOCKS-1:0][`ATS_COUNT_W-1:0] counts,
  input  logic [`ATS_NUM_CLOCKS-1:0]                   ticks,
  output logic [`ATS_NUM_ALARMS-1:0]                   data
);

  atsStatePkg::alarmWrite_t                        wr [2];
  logic [`ATS_NUM_ALARMS-1:0]                      enable;
  logic [`ATS_NUM_ALARMS-1:0]                      repeatOn;
  logic [`ATS_NUM_ALARMS-1:0][`ATS_CLOCK_IDX_W-1:0] clockSel;
  logic [`ATS_NUM_ALARMS-1:0][`ATS_COUNT_W-1:0]    value;
  logic [`ATS_NUM_ALARMS-1:0][1:0]                 hold;      // cycles of data left
  logic [`ATS_NUM_ALARMS-1:0]                      fire;

  assign wr[0] = alarmWrA;
  assign wr[1] = alarmWrB;

  // fire on the edge where the counter steps onto the value
  always_comb begin
    for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
      fire[i] = enable[i] && ticks[clockSel[i]] &&
                ((counts[clockSel[i]] + 1'b1) == value[i]);
      data[i] = (hold[i] != 2'd0);
    end
  end

  //////////////////////////////
  // slot fields

  always_ff @(posedge clk_1x) begin
    for (int w = 0; w < 2; w++) begin
      if (wr[w].valid && (wr[w].index < `ATS_NUM_ALARMS) &&
          (wr[w].kind != atsStatePkg::AW_ENABLE)) begin
        clockSel[wr[w].index] <= wr[w].clockIdx;
        repeatOn[wr[w].index] <= (wr[w].kind == atsStatePkg::AW_SET_ALARM) && wr[w].repEn;
        if (wr[w].kind == atsStatePkg::AW_SET_TIMER)
          value[wr[w].index] <= wr[w].value + counts[wr[w].clockIdx];   // expiry from now
        else
          value[wr[w].index] <= wr[w].value;
      end
    end
  end

  // enables and pulse timers, writes override a same-edge fire
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      enable <= '0;
      hold   <= '0;
    end else begin
      for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
        if (fire[i]) begin
          hold[i] <= 2'd2;                       // restarts a running pulse
          if (!repeatOn[i]) enable[i] <= 1'b0;   // one-shot
        end else if (hold[i] != 2'd0) begin
          hold[i] <= hold[i] - 2'd1;
        end
      end
      for (int w = 0; w < 2; w++) begin
        if (wr[w].valid && (wr[w].index < `ATS_NUM_ALARMS))
          enable[wr[w].index] <= (wr[w].kind == atsStatePkg::AW_ENABLE) ? wr[w].repEn : 1'b1;
      end
    end
  end

  // three high cycles need a fresh fire inside them
  for (genvar g = 0; g < `ATS_NUM_ALARMS; g++) begin : g_pulse
    assert property (@(posedge clk_1x) disable iff (reset)
      data[g] && $past(data[g]) && $past(data[g], 2) |-> $past(fire[g]) || $past(fire[g], 2));
  end

endmodule

//--- rtl/atsTop.sv
// top level of the alarm/timer unit, joining both client ports, the arbiter and the banks
`timescale 1ns/10ps
`include "ats_macros.svh"

module atsTop (
  input  logic                       clk_1x,
  input  logic                       reset,
  input  logic                       req,
  input  logic [`ATS_HALF_W-1:0]     ctrlA,
  input  logic [`ATS_HALF_W-1:0]     ctrlB,
  output logic [1:0]                 stat,
  output logic [`ATS_NUM_ALARMS-1:0] data
);

  atsInstrPkg::hostInstr_t                      instrA, instrB;
  atsStatePkg::clockWrite_t                     clockWrA, clockWrB;
  atsStatePkg::alarmWrite_t                     alarmWrA, alarmWrB;
  logic                                         active;
  logic [`ATS_NUM_CLOCKS-1:0][`ATS_COUNT_W-1:0] counts;
  logic [`ATS_NUM_CLOCKS-1:0]                   ticks;

  hostPort portA (.clk_1x(clk_1x), .reset(reset), .req(req), .active(active),
                  .ctrl(ctrlA), .instr(instrA));
  hostPort portB (.clk_1x(clk_1x), .reset(reset), .req(req), .active(active),
                  .ctrl(ctrlB), .instr(instrB));

  requestArbiter arbiter (
    .clk_1x(clk_1x), .reset(reset),
    .instrA(instrA), .instrB(instrB),
    .active(active), .stat(stat),
    .clockWrA(clockWrA), .clockWrB(clockWrB),
    .alarmWrA(alarmWrA), .alarmWrB(alarmWrB)
  );

  clockBank clocks (
    .clk_1x(clk_1x), .reset(reset),
    .clockWrA(clockWrA), .clockWrB(clockWrB),
    .counts(counts), .ticks(ticks)
  );

  alarmBank alarms (
    .clk_1x(clk_1x), .reset(reset),
    .alarmWrA(alarmWrA), .alarmWrB(alarmWrB),
    .counts(counts), .ticks(ticks),
    .data(data)
  );

endmodule

//--- tests/atsTb.sv
// table-driven testbench for atsTop, sends both clients' instructions and checks stat and data
`timescale 1ns/10ps
`include "ats_macros.svh"

module atsTb;

  typedef struct packed {
    logic [31:0] instrA;    // 0 leaves client A idle
    logic [31:0] instrB;
    logic [1:0]  expStat;
    int          fireIdx;   // -1 when no pulse is allowed
    int          winLo;     // rise window, edges after E
    int          winHi;
    int          period;    // repeat gap in edges, 0 for one-shot
    int          watch;     // quiet edges checked afterwards
  } testRow_t;

  logic                       clk_1x;
  logic                       reset;
  logic                       req;
  logic [`ATS_HALF_W-1:0]     ctrlA;
  logic [`ATS_HALF_W-1:0]     ctrlB;
  logic [1:0]                 stat;
  logic [`ATS_NUM_ALARMS-1:0] data;

  testRow_t rows[$];
  int       errors = 0;
  int       seed   = 87858;

  atsTop DUT (.clk_1x(clk_1x), .reset(reset), .req(req), .ctrlA(ctrlA), .ctrlB(ctrlB),
              .stat(stat), .data(data));

  initial begin
    clk_1x = 1'b0;
    forever #50 clk_1x = ~clk_1x;   // 100 ns
  end

  //////////////////////////////
  // instruction words built field by field

  function automatic logic [31:0] clockWord(input logic [2:0] op, input int clockIdx,
                                            input logic [1:0] enRate, input logic [15:0] count);
    return {op, 4'(clockIdx), 1'b0, enRate, 6'b0, count};   // bit 23 doubles as enable
  endfunction

  function automatic logic [31:0] alarmWord(input logic [2:0] op, input int slot,
                                            input logic repEn, input int clockIdx,
                                            input logic [15:0] value);
    return {op, 5'(slot), repEn, 3'b0, 4'(clockIdx), value};
  endfunction

  function automatic logic [31:0] modeWord(input logic active, input logic clockPerm,
                                           input logic alarmPerm);
    return {`ATS_OP_SET_MODE, active, clockPerm, alarmPerm, 26'b0};
  endfunction

  task automatic addRow(input logic [31:0] a, input logic [31:0] b, input logic [1:0] expStat,
                        input int fireIdx, input int winLo, input int winHi,
                        input int period, input int watch);
    rows.push_back('{a, b, expStat, fireIdx, winLo, winHi, period, watch});
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic reportError(input string msg);
    errors++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  //////////////////////////////
  // row sequencing

  // upper halves with req, lower halves next edge, then on to the execution edge
  task automatic applyRow(input testRow_t r);
    @(posedge clk_1x);
    req   <= 1'b1;
    ctrlA <= r.instrA[31:16];
    ctrlB <= r.instrB[31:16];
    @(posedge clk_1x);
    req   <= 1'b0;             // lower half needs no req
    ctrlA <= r.instrA[15:0];
    ctrlB <= r.instrB[15:0];
    @(posedge clk_1x);
    ctrlA <= '0;
    ctrlB <= '0;
    @(posedge clk_1x);         // E
  endtask

  // rise already seen, bit holds one more cycle then drops
  task automatic checkPulse(input int idx);
    @(negedge clk_1x);
    checkValue($sformatf("data[%0d]", idx), 1, data[idx]);
    @(negedge clk_1x);
    checkValue($sformatf("data[%0d]", idx), 0, data[idx]);
  endtask

  task automatic checkRow(input testRow_t r);
    int   idx;
    int   riseAt;
    int   gap;
    logic seen;
    idx    = r.fireIdx;
    riseAt = -1;
    @(negedge clk_1x);   // settled after E
    checkValue("stat", r.expStat, stat);
    if (idx < 0) begin
      for (int e = 0; e < r.watch; e++) begin
        @(negedge clk_1x);
        if (data != '0) begin
          checkValue("data", '0, data);
          break;
        end
      end
    end else begin
      for (int e = 1; e <= r.winHi + 4; e++) begin   // bounded wait for the rise
        @(negedge clk_1x);
        if (data[idx]) begin
          riseAt = e;
          break;
        end
      end
      if (riseAt < 0) begin
        reportError($sformatf("data[%0d] did not rise within %0d edges of execution",
                              idx, r.winHi + 4));
      end else begin
        if (riseAt < r.winLo || riseAt > r.winHi)
          reportError($sformatf("data[%0d] rose %0d edges after execution, outside %0d to %0d",
                                idx, riseAt, r.winLo, r.winHi));
        checkPulse(idx);
        if (r.period > 0) begin
          gap  = 2;   // pulse edges already gone
          seen = 1'b0;
          while (!seen && gap < r.period + 4) begin
            @(negedge clk_1x);
            gap++;
            seen = data[idx];
          end
          if (!seen) begin
            reportError($sformatf("data[%0d] did not fire again after the counter wrapped", idx));
          end else begin
            checkValue("repeat gap", r.period, gap);
            checkPulse(idx);
          end
        end
        for (int e = 0; e < r.watch; e++) begin
          @(negedge clk_1x);
          if (data[idx]) begin
            reportError($sformatf("data[%0d] rose again without a new fire", idx));
            break;
          end
        end
      end
    end
  endtask

  initial begin
    int ci;
    int si;
    reset <= 1'b1;
    req   <= 1'b0;
    ctrlA <= '0;
    ctrlB <= '0;
    ci = {$random(seed)} % 12;   // keeps ci+1 clear of clocks 13 to 15
    si = {$random(seed)} % `ATS_NUM_ALARMS;

    // one-shot alarm K=5 at 1x, then a wrapping repeat alarm and its disable
    addRow(clockWord(`ATS_OP_SET_CLOCK, 2, `ATS_RATE_1X, 16'h0100),
           alarmWord(`ATS_OP_SET_ALARM, 5, 1'b0, 2, 16'h0105), 2'b11, 5, 5, 5, 0, 20);
    addRow(clockWord(`ATS_OP_SET_CLOCK, 3, `ATS_RATE_1X, 16'hFFF0),
           alarmWord(`ATS_OP_SET_ALARM, 7, 1'b1, 3, 16'hFFF8), 2'b11, 7, 8, 8, 65536, 4);
    addRow(alarmWord(`ATS_OP_EN_ALARM, 7, 1'b0, 0, 16'h0),
           clockWord(`ATS_OP_EN_CLOCK, 3, 2'b10, 16'h0), 2'b11, -1, 0, 0, 0, 65600);
    // timer on a frozen clock, fires D=6 edges after the re-enable
    addRow(clockWord(`ATS_OP_SET_CLOCK, 4, `ATS_RATE_1X, 16'h0200), 32'h0, 2'b11, -1, 0, 0, 0, 0);
    addRow(clockWord(`ATS_OP_EN_CLOCK, 4, 2'b00, 16'h0), 32'h0, 2'b11, -1, 0, 0, 0, 0);
    addRow(32'h0, alarmWord(`ATS_OP_SET_TIMER, 9, 1'b0, 4, 16'd6), 2'b11, -1, 0, 0, 0, 0);
    addRow(clockWord(`ATS_OP_EN_CLOCK, 4, 2'b10, 16'h0), 32'h0, 2'b11, 9, 6, 6, 0, 20);
    // same-target pairs refused, distinct targets accepted
    addRow(clockWord(`ATS_OP_SET_CLOCK, ci, `ATS_RATE_1X, 16'h1000),
           clockWord(`ATS_OP_SET_CLOCK, ci, `ATS_RATE_1X, 16'h2000), 2'b00, -1, 0, 0, 0, 10);
    addRow(clockWord(`ATS_OP_SET_CLOCK, ci, `ATS_RATE_1X, 16'h0),
           clockWord(`ATS_OP_SET_CLOCK, ci + 1, `ATS_RATE_1X, 16'h0), 2'b11, -1, 0, 0, 0, 0);
    addRow(alarmWord(`ATS_OP_SET_ALARM, si, 1'b0, 2, 16'h0),
           alarmWord(`ATS_OP_SET_TIMER, si, 1'b0, 2, 16'd3), 2'b00, -1, 0, 0, 0, 20);
    addRow(alarmWord(`ATS_OP_EN_ALARM, si, 1'b0, 0, 16'h0),
           alarmWord(`ATS_OP_EN_ALARM, (si + 1) % `ATS_NUM_ALARMS, 1'b0, 0, 16'h0),
           2'b11, -1, 0, 0, 0, 0);
    addRow(modeWord(1'b1, 1'b1, 1'b1), modeWord(1'b1, 1'b1, 1'b1), 2'b00, -1, 0, 0, 0, 0);
    // divided rates, K=3 at 2x and K=2 at 4x
    addRow(clockWord(`ATS_OP_SET_CLOCK, 12, `ATS_RATE_2X, 16'h0300),
           alarmWord(`ATS_OP_SET_ALARM, 12, 1'b0, 12, 16'h0303), 2'b11, 12, 5, 6, 0, 20);
    addRow(clockWord(`ATS_OP_SET_CLOCK, 13, `ATS_RATE_4X, 16'h0400),
           alarmWord(`ATS_OP_SET_ALARM, 13, 1'b0, 13, 16'h0402), 2'b11, 13, 5, 8, 0, 20);
    // permissions, undefined opcode, then an inactive device; clock 15 never runs
    addRow(modeWord(1'b1, 1'b1, 1'b0), 32'h0, 2'b11, -1, 0, 0, 0, 0);
    addRow(alarmWord(`ATS_OP_SET_ALARM, 10, 1'b0, 15, 16'h0010),
           alarmWord(`ATS_OP_SET_ALARM, 11, 1'b0, 15, 16'h0010), 2'b10, -1, 0, 0, 0, 10);
    addRow(modeWord(1'b0, 1'b1, 1'b1), {3'b100, 29'h0}, 2'b01, -1, 0, 0, 0, 0);
    addRow(clockWord(`ATS_OP_SET_CLOCK, 5, `ATS_RATE_1X, 16'h0),
           clockWord(`ATS_OP_SET_CLOCK, 6, `ATS_RATE_1X, 16'h0), 2'b01, -1, 0, 0, 0, 10);

    repeat (2) @(posedge clk_1x);
    reset <= 1'b0;

    foreach (rows[i]) begin
      applyRow(rows[i]);
      checkRow(rows[i]);
    end

    $display("atsTb: %0d rows applied, %0d errors", rows.size(), errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- files.f
+incdir+rtl
rtl/atsInstrPkg.sv
rtl/atsStatePkg.sv
rtl/hostPort.sv
rtl/requestArbiter.sv
rtl/clockBank.sv
rtl/alarmBank.sv
rtl/atsTop.sv
tests/atsTb.sv

//--- run.sh
#!/bin/sh
# Build the alarm/timer unit testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f files.f --top-module atsTb -o atsSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/atsSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
exit 1
